// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_noc_router
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= files.f
TSCALE ?= --timescale 1ns/1ns
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(TSCALE) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# a failing concurrent assertion stops the simulator with a nonzero status
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Finished with errors" $(LOG) || \
		! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert $(TSCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
+incdir+.
router_pkg.sv
rx_port.sv
rx_arbiter.sv
flit_fifo.sv
tx_dispatch.sv
noc_router.sv
router_assert.sv
tb_noc_router.sv

// ==== flit_fifo.sv ====
`timescale 1ns/1ns

`include "router_defs.svh"

module flit_fifo
	import router_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  write,
	input  flit_t item_in,
	input  logic  read,
	output flit_t item_out,
	output logic  full,
	output logic  empty
);

	typedef logic [$clog2(`ROUTER_FIFO_DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(`ROUTER_FIFO_DEPTH):0] cnt_t;

	flit_t mem [`ROUTER_FIFO_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	logic do_write;
	logic do_read;

	assign full = (count == cnt_t'(`ROUTER_FIFO_DEPTH));
	assign empty = (count == '0);

	// writes on full and reads on empty are dropped
	assign do_write = write && !full;
	assign do_read = read && !empty;

	// head entry, valid while not empty
	assign item_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= item_in;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== noc_router.sv ====
`timescale 1ns/1ns

`include "router_defs.svh"

// lanes in bit order north, south, east, west, local
module noc_router
	import router_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  dir_t                      rx_req,
	output dir_t                      rx_ack,
	input  flit_t [`ROUTER_PORTS-1:0] rx_data,
	output dir_t                      tx_req,
	input  dir_t                      tx_ack,
	output flit_t [`ROUTER_PORTS-1:0] tx_data,
	output logic [`ROUTER_DEST_W-1:0] table_addr,
	input  dir_t                      table_data
);

	dir_t rx_full;
	dir_t rx_take;
	flit_t [`ROUTER_PORTS-1:0] rx_items;

	logic fifo_write;
	logic fifo_read;
	logic fifo_full;
	logic fifo_empty;
	flit_t fifo_item_in;
	flit_t fifo_item_out;

	// --------------------------------------------------
	// input ports
	// --------------------------------------------------

	generate
		for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_rx
			rx_port rx_port_inst (
				.clk  (clk),
				.rst_n(rst_n),
				.req  (rx_req[i]),
				.ack  (rx_ack[i]),
				.data (rx_data[i]),
				.take (rx_take[i]),
				.full (rx_full[i]),
				.item (rx_items[i])
			);
		end
	endgenerate

	rx_arbiter rx_arbiter_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.full     (rx_full),
		.items    (rx_items),
		.take     (rx_take),
		.fifo_full(fifo_full),
		.write    (fifo_write),
		.item_in  (fifo_item_in)
	);

	// --------------------------------------------------
	// shared fifo and output side
	// --------------------------------------------------

	flit_fifo flit_fifo_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.write   (fifo_write),
		.item_in (fifo_item_in),
		.read    (fifo_read),
		.item_out(fifo_item_out),
		.full    (fifo_full),
		.empty   (fifo_empty)
	);

	tx_dispatch tx_dispatch_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.empty     (fifo_empty),
		.item_out  (fifo_item_out),
		.read      (fifo_read),
		.table_addr(table_addr),
		.table_data(table_data),
		.tx_req    (tx_req),
		.tx_ack    (tx_ack),
		.tx_data   (tx_data)
	);

endmodule

// ==== router_assert.sv ====
`timescale 1ns/1ns

`include "router_defs.svh"

module router_assert
	import router_pkg::*;
(
	input logic                      clk,
	input logic                      rst_n,
	input dir_t                      tx_req,
	input dir_t                      tx_ack,
	input flit_t [`ROUTER_PORTS-1:0] tx_data,
	input dir_t                      rx_ack,
	input dir_t                      table_data,
	input logic                      read
);

	tx_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(tx_req))
		else $error("tx_req raised on more than one lane");

	// req and data held until the chosen lane acks
	tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(tx_req != '0) && ((tx_req & tx_ack) == '0)
		|=> (tx_req == $past(tx_req)) && (tx_data == $past(tx_data)))
		else $error("tx_req or tx_data changed before ack");

	rx_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(rx_ack & $past(rx_ack)) == '0)
		else $error("rx_ack high for two cycles in a row");

	table_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		read |-> $onehot(table_data))
		else $error("table_data not one-hot on a fifo read");

endmodule

bind noc_router router_assert router_assert_inst (
	.clk       (clk),
	.rst_n     (rst_n),
	.tx_req    (tx_req),
	.tx_ack    (tx_ack),
	.tx_data   (tx_data),
	.rx_ack    (rx_ack),
	.table_data(table_data),
	.read      (fifo_read)
);

// ==== router_defs.svh ====
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// flit layout, destination field sits in the upper bits
`define ROUTER_FLIT_W 8
`define ROUTER_DEST_W 4

// north, south, east, west, local
`define ROUTER_PORTS 5

// shared fifo depth, keep it a power of two
`define ROUTER_FIFO_DEPTH 4

`endif

// ==== router_pkg.sv ====
`include "router_defs.svh"

package router_pkg;

	// --------------------------------------------------
	// flit and port types
	// --------------------------------------------------

	typedef struct packed {
		logic [`ROUTER_DEST_W-1:0] dest;
		logic [`ROUTER_FLIT_W-`ROUTER_DEST_W-1:0] payload;
	} flit_t;

	// one-hot port mask, bit order as in the index names below
	typedef logic [`ROUTER_PORTS-1:0] dir_t;

	// index into port masks and lane arrays
	typedef logic [$clog2(`ROUTER_PORTS)-1:0] port_idx_t;

	localparam port_idx_t port_north = port_idx_t'(0);
	localparam port_idx_t port_south = port_idx_t'(1);
	localparam port_idx_t port_east = port_idx_t'(2);
	localparam port_idx_t port_west = port_idx_t'(3);
	localparam port_idx_t port_local = port_idx_t'(4);

endpackage

// ==== rx_arbiter.sv ====
`timescale 1ns/1ns

`include "router_defs.svh"

module rx_arbiter
	import router_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  dir_t                      full,
	input  flit_t [`ROUTER_PORTS-1:0] items,
	output dir_t                      take,
	input  logic                      fifo_full,
	output logic                      write,
	output flit_t                     item_in
);

	port_idx_t ptr;
	port_idx_t sel;
	logic found;

	// --------------------------------------------------
	// round-robin search
	// --------------------------------------------------

	// first full buffer at or after the pointer
	always_comb begin
		int idx;
		found = 1'b0;
		sel = ptr;
		for (int k = 0; k < `ROUTER_PORTS; k++) begin
			idx = (int'(ptr) + k) % `ROUTER_PORTS;
			if (!found && full[idx]) begin
				found = 1'b1;
				sel = port_idx_t'(idx);
			end
		end
	end

	// take and fifo write happen in the same cycle
	assign write = found && !fifo_full;
	assign take = write ? (dir_t'(1) << sel) : '0;
	assign item_in = items[sel];

	// --------------------------------------------------
	// pointer update
	// --------------------------------------------------

	// next search starts after the port just served
	always_ff @(posedge clk) begin
		if (!rst_n)
			ptr <= port_north;
		else if (write)
			ptr <= (sel == port_local) ? port_north : sel + 1'b1;
	end

endmodule

// ==== rx_port.sv ====
`timescale 1ns/1ns

module rx_port
	import router_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  req,
	output logic  ack,
	input  flit_t data,
	input  logic  take,
	output logic  full,
	output flit_t item
);

	logic load;

	// req may still carry the old flit right after an ack
	assign load = req && !full && !ack;

	// handshake and buffer state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
			full <= 1'b0;
		end else begin
			ack <= load;
			if (load)
				full <= 1'b1;
			else if (take)
				full <= 1'b0;
		end
	end

	// holding register
	always_ff @(posedge clk) begin
		if (load)
			item <= data;
	end

endmodule

// ==== tb_noc_router.sv ====
`timescale 1ns/1ns

`include "router_defs.svh"

module tb_noc_router
	import router_pkg::*;
();

	localparam int n_rows = 16;
	localparam int row_limit = 200;
	localparam int n_ports = `ROUTER_PORTS;

	logic clk;
	logic rst_n = 1'b0;
	dir_t rx_req = '0;
	dir_t rx_ack;
	flit_t [`ROUTER_PORTS-1:0] rx_data = '0;
	dir_t tx_req;
	dir_t tx_ack = '0;
	flit_t [`ROUTER_PORTS-1:0] tx_data;
	logic [`ROUTER_DEST_W-1:0] table_addr;
	dir_t table_data;

	// each row holds input port, flit {dest, payload} and output stall
	logic [15:0] rows [n_rows] = '{
		16'h0_30_0, 16'h1_71_1, 16'h2_02_0, 16'h3_e3_2,
		16'h4_54_0, 16'h0_95_3, 16'h1_c6_0, 16'h2_17_1,
		16'h3_48_0, 16'h4_b9_4, 16'h0_fa_0, 16'h1_2b_2,
		16'h2_8c_0, 16'h3_6d_1, 16'h4_de_0, 16'h0_af_5
	};

	flit_t pend [n_ports][$];
	// expected flits with one queue per input and output pair
	flit_t sb [n_ports*n_ports][$];

	logic [31:0] lfsr = 32'h4065;
	int stall [n_ports];
	int ack_cnt [n_ports];
	int stall_base = 0;
	logic hold = 1'b0;
	logic fair = 1'b0;
	int accepted = 0;
	int received = 0;
	int sent = 0;
	int agent_errors = 0;
	int test_errors = 0;
	int errs_seen = 0;
	int n_tests = 0;
	int n_failed = 0;

	noc_router noc_router_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx_req    (rx_req),
		.rx_ack    (rx_ack),
		.rx_data   (rx_data),
		.tx_req    (tx_req),
		.tx_ack    (tx_ack),
		.tx_data   (tx_data),
		.table_addr(table_addr),
		.table_data(table_data)
	);

	// route table model answers in the same cycle
	assign table_data = dir_t'(1) << route_port(table_addr);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int route_port(logic [`ROUTER_DEST_W-1:0] dest);
		return int'(dest) % n_ports;
	endfunction

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int outstanding();
		int n;
		n = 0;
		for (int q = 0; q < n_ports * n_ports; q++)
			n += sb[q].size();
		return n;
	endfunction

	// flit must be the head of one pair queue for this output
	function automatic void check_output(int o, flit_t f);
		logic hit;
		logic any;
		flit_t head;
		int q;
		hit = 1'b0;
		any = 1'b0;
		head = '0;
		for (int i = 0; i < n_ports; i++) begin
			q = i * n_ports + o;
			if (!hit && sb[q].size() > 0) begin
				if (sb[q][0] == f) begin
					hit = 1'b1;
					void'(sb[q].pop_front());
				end else if (!any) begin
					any = 1'b1;
					head = sb[q][0];
				end
			end
		end
		received++;
		assert (hit) else begin
			if (any)
				$display("Mismatch at %0t ns: tx_data[%0d] expected %h got %h",
					$time, o, head, f);
			else
				$display("Flit %h came out on port %0d at %0t ns, none expected", f, o, $time);
			agent_errors++;
		end
	endfunction

	// --------------------------------------------------
	// input drivers and output responders
	// --------------------------------------------------

	always @(posedge clk) begin : agents
		int cnt_min;
		int cnt_max;
		if (!rst_n) begin
			rx_req <= '0;
			tx_ack <= '0;
			for (int p = 0; p < n_ports; p++) begin
				stall[p] = -1;
				ack_cnt[p] = 0;
			end
		end else begin
			cnt_min = n_rows;
			cnt_max = 0;
			for (int p = 0; p < n_ports; p++) begin
				if (rx_req[p] && rx_ack[p]) begin
					accepted++;
					ack_cnt[p]++;
					// next flit rides on the same req
					if (pend[p].size() > 0)
						rx_data[p] <= pend[p].pop_front();
					else
						rx_req[p] <= 1'b0;
				end else if (!rx_req[p] && pend[p].size() > 0) begin
					rx_req[p] <= 1'b1;
					rx_data[p] <= pend[p].pop_front();
				end
				if (ack_cnt[p] > cnt_max)
					cnt_max = ack_cnt[p];
				if (ack_cnt[p] < cnt_min)
					cnt_min = ack_cnt[p];
			end
			if (fair) begin
				// no port gets its next ack while another is still one behind
				assert (cnt_max - cnt_min <= 1) else begin
					$display("At %0t ns one port is two acks ahead of another", $time);
					agent_errors++;
				end
			end else begin
				for (int p = 0; p < n_ports; p++)
					ack_cnt[p] = 0;
			end
			for (int o = 0; o < n_ports; o++) begin
				if (tx_ack[o]) begin
					tx_ack[o] <= 1'b0;
				end else if (tx_req[o] && !hold) begin
					if (stall[o] < 0)
						stall[o] = stall_base + int'(rand_bits(2));
					if (stall[o] == 0) begin
						check_output(o, tx_data[o]);
						tx_ack[o] <= 1'b1;
						stall[o] = -1;
					end else begin
						stall[o]--;
					end
				end
			end
		end
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	// call at a falling edge
	task automatic queue_row(int r);
		int p;
		flit_t f;
		p = int'(rows[r][15:12]);
		f = flit_t'(rows[r][11:4]);
		pend[p].push_back(f);
		sb[p * n_ports + route_port(f.dest)].push_back(f);
		sent++;
	endtask

	task automatic wait_drain(int limit);
		int n;
		n = 0;
		while (outstanding() > 0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		assert (outstanding() == 0) else begin
			$display("%0d flits never came out within %0d cycles", outstanding(), limit);
			test_errors++;
		end
	endtask

	task automatic report_test(string name);
		int errs;
		errs = test_errors + agent_errors;
		n_tests++;
		if (errs == errs_seen) begin
			$display("test %0d %s: pass", n_tests, name);
		end else begin
			$display("test %0d %s: fail, %0d errors", n_tests, name, errs - errs_seen);
			n_failed++;
		end
		errs_seen = errs;
	endtask

	initial begin : main
		int acc_start;
		int acc_mid;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		repeat (10) begin
			@(negedge clk);
			assert (rx_ack == '0) else begin
				$display("Mismatch at %0t ns: rx_ack expected %b got %b", $time, 5'b0, rx_ack);
				test_errors++;
			end
			assert (tx_req == '0) else begin
				$display("Mismatch at %0t ns: tx_req expected %b got %b", $time, 5'b0, tx_req);
				test_errors++;
			end
		end
		report_test("quiet after reset");

		for (int r = 0; r < n_rows; r++) begin
			@(negedge clk);
			stall_base = int'(rows[r][3:0]);
			queue_row(r);
			wait_drain(row_limit);
		end
		report_test("single flits");

		@(negedge clk);
		stall_base = 0;
		for (int r = 0; r < n_rows; r++)
			queue_row(r);
		wait_drain(row_limit);
		assert (received == sent) else begin
			$display("Mismatch at %0t ns: flit count expected %0d got %0d",
				$time, sent, received);
			test_errors++;
		end
		report_test("count and order");

		// outputs stalled for 40 cycles
		@(negedge clk);
		hold = 1'b1;
		acc_start = accepted;
		for (int r = 0; r < n_rows; r++)
			queue_row(r);
		repeat (30) @(negedge clk);
		acc_mid = accepted;
		repeat (10) @(negedge clk);
		assert (accepted == acc_mid) else begin
			$display("rx_ack still given at %0t ns with all outputs stalled", $time);
			test_errors++;
		end
		assert (accepted - acc_start <= `ROUTER_FIFO_DEPTH + 6) else begin
			$display("Mismatch at %0t ns: accepted flits expected at most %0d got %0d",
				$time, `ROUTER_FIFO_DEPTH + 6, accepted - acc_start);
			test_errors++;
		end
		hold = 1'b0;
		wait_drain(row_limit);
		report_test("back-pressure");

		// rows 0 to 14 give three flits to every input
		@(negedge clk);
		fair = 1'b1;
		for (int r = 0; r < 3 * n_ports; r++)
			queue_row(r);
		wait_drain(row_limit);
		@(negedge clk);
		fair = 1'b0;
		report_test("contention");

		$display("tests %0d, failed %0d, errors %0d",
			n_tests, n_failed, test_errors + agent_errors);
		if (test_errors + agent_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin : watchdog
		repeat (row_limit * n_rows) @(posedge clk);
		$display("Timeout: run not done after %0d cycles", row_limit * n_rows);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== tx_dispatch.sv ====
`timescale 1ns/1ns

`include "router_defs.svh"

module tx_dispatch
	import router_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      empty,
	input  flit_t                     item_out,
	output logic                      read,
	output logic [`ROUTER_DEST_W-1:0] table_addr,
	input  dir_t                      table_data,
	output dir_t                      tx_req,
	input  dir_t                      tx_ack,
	output flit_t [`ROUTER_PORTS-1:0] tx_data
);

	typedef enum logic {
		st_idle,
		st_send
	} state_t;

	state_t state;
	flit_t flit_q;
	dir_t dir_q;

	// --------------------------------------------------
	// route lookup and pop
	// --------------------------------------------------

	// table answers in the same cycle
	assign table_addr = item_out.dest;

	// pop only from idle, one flit in flight
	assign read = (state == st_idle) && !empty;

	always_ff @(posedge clk) begin
		if (read) begin
			flit_q <= item_out;
			dir_q <= table_data;
		end
	end

	// --------------------------------------------------
	// output handshake
	// --------------------------------------------------

	// req only on the routed lane, data on all lanes
	assign tx_req = (state == st_send) ? dir_q : '0;
	assign tx_data = {`ROUTER_PORTS{flit_q}};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (read)
						state <= st_send;
				end
				st_send: begin
					// back to idle once the chosen lane acks
					if (|(tx_ack & dir_q))
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule
